// ==== cu_pkg.sv ====
package cu_pkg;

    // ------------------------------------------------------------
    // Register index and ALU operation
    // ------------------------------------------------------------
    typedef logic [1:0] reg_idx_t;

    typedef enum logic [3:0] {
        OP_MOV_A = 4'd0,
        OP_MOV_B = 4'd1,
        OP_ADD   = 4'd2,
        OP_SUB   = 4'd3,
        OP_AND   = 4'd4,
        OP_OR    = 4'd5,
        OP_DEC   = 4'd6,
        OP_INC   = 4'd7,
        OP_NEG   = 4'd8,
        OP_NOT   = 4'd9,
        OP_RLC   = 4'd10,
        OP_RRC   = 4'd11,
        OP_SETC  = 4'd12,
        OP_CLRC  = 4'd13,
        OP_DEC_A = 4'd14
    } alu_op_t;

    // Opcode in bits 7:4 of the instruction byte
    localparam logic [3:0] OPC_NOP   = 4'd0;
    localparam logic [3:0] OPC_MOV   = 4'd1;
    localparam logic [3:0] OPC_ADD   = 4'd2;
    localparam logic [3:0] OPC_SUB   = 4'd3;
    localparam logic [3:0] OPC_AND   = 4'd4;
    localparam logic [3:0] OPC_OR    = 4'd5;
    localparam logic [3:0] OPC_ROT   = 4'd6;   // RLC RRC SETC CLRC
    localparam logic [3:0] OPC_STACK = 4'd7;   // PUSH POP OUT IN
    localparam logic [3:0] OPC_UNARY = 4'd8;   // NOT NEG INC DEC
    localparam logic [3:0] OPC_JCOND = 4'd9;   // JZ JN JC JV
    localparam logic [3:0] OPC_LOOP  = 4'd10;
    localparam logic [3:0] OPC_JUMP  = 4'd11;  // JMP CALL RET RTI
    localparam logic [3:0] OPC_LONG  = 4'd12;  // Two byte forms
    localparam logic [3:0] OPC_LDD   = 4'd13;
    localparam logic [3:0] OPC_STD   = 4'd14;

    // ------------------------------------------------------------
    // Datapath selects
    // ------------------------------------------------------------
    typedef enum logic [1:0] {
        SRC_A_REG    = 2'd0,
        SRC_A_IMM    = 2'd1,
        SRC_A_FWD    = 2'd2,
        SRC_A_INPORT = 2'd3
    } src_a_t;

    typedef enum logic [1:0] {
        SRC_B_REG = 2'd0,
        SRC_B_PC  = 2'd1,
        SRC_B_FWD = 2'd2
    } src_b_t;

    typedef enum logic [1:0] {
        FLAGS_KEEP = 2'd0,
        FLAGS_ZN   = 2'd1,
        FLAGS_ALL  = 2'd2
    } flag_mode_t;

    typedef enum logic [2:0] {
        JK_NONE = 3'd0,
        JK_JZ   = 3'd1,
        JK_JN   = 3'd2,
        JK_JC   = 3'd3,
        JK_JV   = 3'd4,
        JK_JMP  = 3'd5,
        JK_RET  = 3'd6,   // RET and RTI
        JK_LOOP = 3'd7
    } jmp_kind_t;

    typedef struct packed {
        logic       reg_write;
        logic       mem_read;     // Write back from memory
        logic       mem_write;
        alu_op_t    alu_op;
        flag_mode_t flag_change;
        reg_idx_t   src1;
        reg_idx_t   src2;
        src_a_t     alu_src_a;
        src_b_t     alu_src_b;
        reg_idx_t   dest;
        logic       sp_inc;
        logic       sp_dec;
        logic       read_out;
        jmp_kind_t  jmp;
        logic       store_pc;
        logic       return_flags;
    } ctrl_word_t;

    // ------------------------------------------------------------
    // Hazard, flush and interrupt status
    // ------------------------------------------------------------
    typedef enum logic [1:0] {
        FWD_EX   = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2,
        FWD_NONE = 2'd3   // Register file value
    } fwd_sel_t;

    typedef struct packed {
        fwd_sel_t a;
        fwd_sel_t b;
    } fwd_t;

    typedef struct packed {
        logic     is_load;
        logic     writes;
        reg_idx_t dest;
    } dest_tag_t;

    typedef struct packed {
        logic f;
        logic d;
        logic ex;
    } flush_t;

    typedef struct packed {
        logic ack;
        logic active;
        logic ret;
    } intr_status_t;

endpackage

// ==== instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder #(
    parameter cu_pkg::reg_idx_t SP_REG = 2'd3
) (
    input  logic [7:0]         i_instr,
    output cu_pkg::ctrl_word_t o_word
);
    import cu_pkg::*;

    logic [3:0] opcode;
    reg_idx_t   ra;
    reg_idx_t   rb;

    assign opcode = i_instr[7:4];
    assign ra     = i_instr[3:2];
    assign rb     = i_instr[1:0];

    always_comb begin
        o_word           = '0;
        o_word.alu_src_a = SRC_A_IMM;   // No register read by default
        o_word.alu_src_b = SRC_B_PC;

        case (opcode)
            OPC_MOV: begin
                o_word.alu_op    = OP_MOV_B;
                o_word.alu_src_b = SRC_B_REG;
                o_word.src2      = rb;
                o_word.dest      = ra;
                o_word.reg_write = 1'b1;
            end
            OPC_ADD, OPC_SUB, OPC_AND, OPC_OR: begin
                o_word.alu_op      = alu_op_t'(opcode);   // Same codes for these four
                o_word.alu_src_a   = SRC_A_REG;
                o_word.alu_src_b   = SRC_B_REG;
                o_word.src1        = ra;
                o_word.src2        = rb;
                o_word.dest        = ra;
                o_word.reg_write   = 1'b1;
                o_word.flag_change = (opcode inside {OPC_ADD, OPC_SUB}) ? FLAGS_ALL : FLAGS_ZN;
            end
            OPC_ROT: begin
                case (ra)
                    2'd0, 2'd1: begin   // RLC RRC
                        o_word.alu_op    = (ra == 2'd0) ? OP_RLC : OP_RRC;
                        o_word.alu_src_b = SRC_B_REG;
                        o_word.src2      = rb;
                        o_word.dest      = rb;
                        o_word.reg_write = 1'b1;
                    end
                    2'd2:    o_word.alu_op = OP_SETC;
                    default: o_word.alu_op = OP_CLRC;
                endcase
            end
            OPC_STACK: begin
                case (ra)
                    2'd0: begin   // PUSH
                        o_word.alu_src_a = SRC_A_REG;
                        o_word.alu_src_b = SRC_B_REG;
                        o_word.src1      = SP_REG;
                        o_word.src2      = rb;
                        o_word.mem_write = 1'b1;
                        o_word.sp_dec    = 1'b1;
                    end
                    2'd1: begin   // POP
                        o_word.alu_src_a = SRC_A_REG;
                        o_word.src1      = SP_REG;
                        o_word.dest      = rb;
                        o_word.mem_read  = 1'b1;
                        o_word.reg_write = 1'b1;
                        o_word.sp_inc    = 1'b1;
                    end
                    2'd2: begin   // OUT
                        o_word.alu_op    = OP_MOV_B;
                        o_word.alu_src_b = SRC_B_REG;
                        o_word.src2      = rb;
                        o_word.read_out  = 1'b1;
                    end
                    default: begin   // IN
                        o_word.alu_op    = OP_MOV_A;
                        o_word.alu_src_a = SRC_A_INPORT;
                        o_word.dest      = rb;
                        o_word.reg_write = 1'b1;
                    end
                endcase
            end
            OPC_UNARY: begin
                case (ra)
                    2'd0:    o_word.alu_op = OP_NOT;
                    2'd1:    o_word.alu_op = OP_NEG;
                    2'd2:    o_word.alu_op = OP_INC;
                    default: o_word.alu_op = OP_DEC;
                endcase
                o_word.alu_src_b   = SRC_B_REG;
                o_word.src2        = rb;
                o_word.dest        = rb;
                o_word.reg_write   = 1'b1;
                o_word.flag_change = ra[1] ? FLAGS_ALL : FLAGS_ZN;   // INC DEC touch carry
            end
            OPC_JCOND: begin
                o_word.jmp       = jmp_kind_t'({1'b0, ra} + 3'd1);   // JZ JN JC JV
                o_word.alu_src_b = SRC_B_REG;
                o_word.src2      = rb;
            end
            OPC_LOOP: begin
                o_word.alu_op    = OP_DEC_A;
                o_word.alu_src_a = SRC_A_REG;
                o_word.alu_src_b = SRC_B_REG;
                o_word.src1      = ra;
                o_word.src2      = rb;
                o_word.dest      = ra;
                o_word.reg_write = 1'b1;
                o_word.jmp       = JK_LOOP;
            end
            OPC_JUMP: begin
                case (ra)
                    2'd0: begin   // JMP
                        o_word.jmp       = JK_JMP;
                        o_word.alu_src_b = SRC_B_REG;
                        o_word.src2      = rb;
                    end
                    2'd1: begin   // CALL
                        o_word.jmp       = JK_JMP;
                        o_word.alu_src_a = SRC_A_REG;
                        o_word.alu_src_b = SRC_B_REG;
                        o_word.src1      = SP_REG;
                        o_word.src2      = rb;
                        o_word.sp_dec    = 1'b1;
                        o_word.mem_write = 1'b1;
                        o_word.store_pc  = 1'b1;
                    end
                    default: begin   // RET RTI
                        o_word.jmp          = JK_RET;
                        o_word.alu_src_a    = SRC_A_REG;
                        o_word.src1         = SP_REG;
                        o_word.sp_inc       = 1'b1;
                        o_word.return_flags = ra[0];   // RTI only
                    end
                endcase
            end
            OPC_LONG: begin
                case (ra)
                    2'd0: begin   // Load immediate
                        o_word.dest      = rb;
                        o_word.reg_write = 1'b1;
                    end
                    2'd1: begin   // Load from immediate address
                        o_word.mem_read  = 1'b1;
                        o_word.dest      = rb;
                        o_word.reg_write = 1'b1;
                    end
                    2'd2: begin   // Store to immediate address
                        o_word.mem_write = 1'b1;
                        o_word.src2      = rb;
                    end
                    default: ;
                endcase
            end
            OPC_LDD: begin
                o_word.mem_read  = 1'b1;
                o_word.reg_write = 1'b1;
                o_word.dest      = rb;
                o_word.src1      = ra;
            end
            OPC_STD: begin
                o_word.mem_write = 1'b1;
                o_word.src1      = ra;
                o_word.src2      = rb;
            end
            default: ;   // NOP and opcode 15
        endcase
    end

    // A single memory access per instruction
    always_comb begin
        assert (!(o_word.mem_read && o_word.mem_write))
            else $error("decoder drives mem_read and mem_write together");
    end

endmodule

// ==== intr_sequencer.sv ====
`timescale 1ns/1ps

module intr_sequencer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_intr,
    output cu_pkg::intr_status_t o_status
);
    import cu_pkg::*;

    typedef enum logic [1:0] {
        S_NORMAL = 2'd0,
        S_RISE   = 2'd1,
        S_ACTIVE = 2'd2,
        S_FALL   = 2'd3
    } state_t;

    state_t state;
    state_t state_next;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= S_NORMAL;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        case (state)
            S_NORMAL: state_next = i_intr ? S_RISE : S_NORMAL;
            S_RISE:   state_next = S_ACTIVE;                    // Ack lasts one cycle
            S_ACTIVE: state_next = i_intr ? S_ACTIVE : S_FALL;
            default:  state_next = S_NORMAL;
        endcase
    end

    assign o_status.ack    = (state == S_RISE);
    assign o_status.active = (state == S_ACTIVE);
    assign o_status.ret    = (state == S_FALL);   // Fetch inserts the return

    // Interrupt window always ends before a new one can begin
    assert property (@(posedge clk) disable iff (reset) o_status.ack |=> !o_status.ack)
        else $error("interrupt ack held for two cycles");

endmodule

// ==== issue_stage.sv ====
`timescale 1ns/1ps

module issue_stage #(
    parameter cu_pkg::reg_idx_t SP_REG = 2'd3
) (
    input  logic               clk,
    input  logic               reset,
    input  cu_pkg::ctrl_word_t i_dec_word,
    input  logic               i_intr_ack,
    output cu_pkg::ctrl_word_t o_ctrl,
    output cu_pkg::fwd_t       o_fwd,
    output logic               o_stall
);
    import cu_pkg::*;

    ctrl_word_t        intr_word;
    dest_tag_t         cur_tag;
    dest_tag_t         ex_next;
    dest_tag_t [2:0]   hist;       // 0 EX, 1 MEM, 2 WB
    logic              stall_a;
    logic              stall_b;

    // First older writer of r decides the source
    function automatic fwd_sel_t lookup(input logic check, input reg_idx_t r,
                                        input dest_tag_t [2:0] h, output logic load_hit);
        fwd_sel_t sel;
        sel      = FWD_NONE;
        load_hit = 1'b0;
        if (check) begin
            if (h[0].writes && h[0].dest == r) begin
                sel      = FWD_EX;
                load_hit = h[0].is_load;   // Load data not ready yet
            end else if (h[1].writes && h[1].dest == r) begin
                sel = FWD_MEM;
            end else if (h[2].writes && h[2].dest == r) begin
                sel = FWD_WB;
            end
        end
        return sel;
    endfunction

    // ------------------------------------------------------------
    // Issued word
    // ------------------------------------------------------------
    always_comb begin
        intr_word           = '0;
        intr_word.src1      = SP_REG;       // Push PC onto the stack
        intr_word.alu_src_a = SRC_A_REG;
        intr_word.alu_src_b = SRC_B_PC;
        intr_word.sp_dec    = 1'b1;
        intr_word.mem_write = 1'b1;
    end

    assign o_ctrl = i_intr_ack ? intr_word : i_dec_word;

    // ------------------------------------------------------------
    // Destination history and forwarding
    // ------------------------------------------------------------
    assign cur_tag.is_load = o_ctrl.mem_read;
    assign cur_tag.writes  = o_ctrl.reg_write;
    assign cur_tag.dest    = o_ctrl.dest;
    assign ex_next         = o_stall ? dest_tag_t'('0) : cur_tag;   // Bubble while stalled

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hist <= '0;
        end else begin
            hist <= {hist[1], hist[0], ex_next};
        end
    end

    always_comb begin
        o_fwd.a = lookup(o_ctrl.alu_src_a == SRC_A_REG, o_ctrl.src1, hist, stall_a);
        o_fwd.b = lookup(o_ctrl.alu_src_b == SRC_B_REG, o_ctrl.src2, hist, stall_b);
    end

    assign o_stall = stall_a | stall_b;   // Holds fetch and decode

    // Only a load in EX can hold the front end
    assert property (@(posedge clk) disable iff (reset)
                     o_stall |-> hist[0].is_load && hist[0].writes)
        else $error("stall raised without a load in EX");

endmodule

// ==== flush_sequencer.sv ====
`timescale 1ns/1ps

module flush_sequencer (
    input  logic              clk,
    input  logic              reset,
    input  cu_pkg::jmp_kind_t i_jmp,
    input  logic              i_branch_taken,
    output cu_pkg::flush_t    o_flush
);
    import cu_pkg::*;

    typedef enum logic [2:0] {
        S_NORMAL = 3'd0,
        S_UNCOND = 3'd1,   // JMP and CALL
        S_DELAY1 = 3'd2,   // RET waits for the stack read
        S_DELAY2 = 3'd3,
        S_COND   = 3'd4
    } state_t;

    state_t state;
    state_t state_next;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= S_NORMAL;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = S_NORMAL;
        case (state)
            S_NORMAL: begin
                case (i_jmp)
                    JK_JMP:  state_next = S_UNCOND;
                    JK_RET:  state_next = S_DELAY1;
                    JK_NONE: state_next = S_NORMAL;
                    default: state_next = S_COND;     // JZ JN JC JV LOOP
                endcase
            end
            S_DELAY1: state_next = S_DELAY2;
            default:  state_next = S_NORMAL;          // Jumps seen here are dropped
        endcase
    end

    always_comb begin
        o_flush = '0;
        case (state)
            S_UNCOND: begin
                o_flush.f = 1'b1;
                o_flush.d = 1'b1;
            end
            S_DELAY2: begin
                o_flush = '1;
            end
            S_COND: begin
                o_flush.f = i_branch_taken;   // Resolved in EX this cycle
                o_flush.d = i_branch_taken;
            end
            default: ;
        endcase
    end

    // EX flush only ends a delayed return
    assert property (@(posedge clk) disable iff (reset)
                     o_flush.ex |-> state == S_DELAY2 && $past(state == S_DELAY1))
        else $error("execute flush outside a delayed return");

endmodule

// ==== control_unit.sv ====
`timescale 1ns/1ps

module control_unit #(
    parameter cu_pkg::reg_idx_t SP_REG = 2'd3
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [7:0]           i_instr,
    input  logic                 i_branch_taken,
    input  logic                 i_intr,
    output cu_pkg::ctrl_word_t   o_ctrl,
    output cu_pkg::fwd_t         o_fwd,
    output logic                 o_stall,
    output cu_pkg::flush_t       o_flush,
    output cu_pkg::intr_status_t o_intr
);
    import cu_pkg::*;

    ctrl_word_t dec_word;

    instr_decoder #(.SP_REG(SP_REG)) u_instr_decoder (
        .i_instr (i_instr),
        .o_word  (dec_word)
    );

    intr_sequencer u_intr_sequencer (
        .clk      (clk),
        .reset    (reset),
        .i_intr   (i_intr),
        .o_status (o_intr)
    );

    // Interrupt word takes the decode slot during ack
    issue_stage #(.SP_REG(SP_REG)) u_issue_stage (
        .clk        (clk),
        .reset      (reset),
        .i_dec_word (dec_word),
        .i_intr_ack (o_intr.ack),
        .o_ctrl     (o_ctrl),
        .o_fwd      (o_fwd),
        .o_stall    (o_stall)
    );

    flush_sequencer u_flush_sequencer (
        .clk            (clk),
        .reset          (reset),
        .i_jmp          (o_ctrl.jmp),
        .i_branch_taken (i_branch_taken),
        .o_flush        (o_flush)
    );

endmodule

// ==== tb_control_unit.sv ====
`timescale 1ns/1ps

module tb_control_unit;
    import cu_pkg::*;

    localparam int N_RANDOM     = 300;
    localparam int N_HAZARD     = 200;
    localparam int N_INTR       = 12;
    localparam int MAX_HIGH     = 8;
    localparam int INTR_GAP     = 4;
    localparam int N_JUMP       = 150;
    localparam int TOTAL_CYCLES = 16 + 2 * (N_RANDOM + N_HAZARD + N_JUMP)
                                  + 2 * N_INTR * (MAX_HIGH + INTR_GAP) + 20;
    localparam int TIMEOUT_NS   = TOTAL_CYCLES * 20 + 2000;

    logic         clk;
    logic         reset;
    logic [7:0]   i_instr;
    logic         i_branch_taken;
    logic         i_intr;
    ctrl_word_t   o_ctrl;
    fwd_t         o_fwd;
    logic         o_stall;
    flush_t       o_flush;
    intr_status_t o_intr;

    logic [31:0]  rng_state;
    int           error_count;

    // Model state, advanced on each falling edge
    dest_tag_t    m_hist [0:2];   // EX MEM WB
    int           m_intr_st;      // 0 idle, 1 ack, 2 active, 3 return
    int           m_flush_st;     // 0 idle, 1 uncond, 2 delay1, 3 delay2, 4 cond
    logic         exp_stall;

    ctrl_word_t   e_ctrl;
    fwd_t         e_fwd;
    logic         e_stall;
    flush_t       e_flush;
    intr_status_t e_intr;
    logic         load_a;
    logic         load_b;

    control_unit #(.SP_REG(2'd3)) u_control_unit (
        .clk            (clk),
        .reset          (reset),
        .i_instr        (i_instr),
        .i_branch_taken (i_branch_taken),
        .i_intr         (i_intr),
        .o_ctrl         (o_ctrl),
        .o_fwd          (o_fwd),
        .o_stall        (o_stall),
        .o_flush        (o_flush),
        .o_intr         (o_intr)
    );

    always #10 clk = ~clk;

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    function automatic ctrl_word_t decode_model(input logic [7:0] b);
        ctrl_word_t w;
        logic [3:0] opc;
        reg_idx_t   ra;
        reg_idx_t   rb;
        opc         = b[7:4];
        ra          = b[3:2];
        rb          = b[1:0];
        w           = '0;
        w.alu_src_a = SRC_A_IMM;
        w.alu_src_b = SRC_B_PC;
        case (opc)
            4'd1: begin   // MOV ra, rb
                w.alu_op = OP_MOV_B;
                w.alu_src_b = SRC_B_REG;
                w.src2 = rb;
                w.dest = ra;
                w.reg_write = 1'b1;
            end
            4'd2, 4'd3, 4'd4, 4'd5: begin
                case (opc)
                    4'd2:    w.alu_op = OP_ADD;
                    4'd3:    w.alu_op = OP_SUB;
                    4'd4:    w.alu_op = OP_AND;
                    default: w.alu_op = OP_OR;
                endcase
                w.flag_change = (opc < 4'd4) ? FLAGS_ALL : FLAGS_ZN;
                w.alu_src_a = SRC_A_REG;
                w.alu_src_b = SRC_B_REG;
                w.src1 = ra;
                w.src2 = rb;
                w.dest = ra;
                w.reg_write = 1'b1;
            end
            4'd6: begin
                if (ra == 2'd2) begin
                    w.alu_op = OP_SETC;
                end else if (ra == 2'd3) begin
                    w.alu_op = OP_CLRC;
                end else begin
                    w.alu_op = (ra == 2'd1) ? OP_RRC : OP_RLC;
                    w.alu_src_b = SRC_B_REG;
                    w.src2 = rb;
                    w.dest = rb;
                    w.reg_write = 1'b1;
                end
            end
            4'd7: begin
                case (ra)
                    2'd0: begin   // PUSH
                        w.alu_src_a = SRC_A_REG;
                        w.alu_src_b = SRC_B_REG;
                        w.src1 = 2'd3;
                        w.src2 = rb;
                        w.mem_write = 1'b1;
                        w.sp_dec = 1'b1;
                    end
                    2'd1: begin   // POP
                        w.alu_src_a = SRC_A_REG;
                        w.src1 = 2'd3;
                        w.dest = rb;
                        w.mem_read = 1'b1;
                        w.reg_write = 1'b1;
                        w.sp_inc = 1'b1;
                    end
                    2'd2: begin   // OUT
                        w.alu_op = OP_MOV_B;
                        w.alu_src_b = SRC_B_REG;
                        w.src2 = rb;
                        w.read_out = 1'b1;
                    end
                    default: begin
                        w.alu_op = OP_MOV_A;
                        w.alu_src_a = SRC_A_INPORT;
                        w.dest = rb;
                        w.reg_write = 1'b1;
                    end
                endcase
            end
            4'd8: begin
                case (ra)
                    2'd0:    w.alu_op = OP_NOT;
                    2'd1:    w.alu_op = OP_NEG;
                    2'd2:    w.alu_op = OP_INC;
                    default: w.alu_op = OP_DEC;
                endcase
                w.flag_change = (ra >= 2'd2) ? FLAGS_ALL : FLAGS_ZN;
                w.alu_src_b = SRC_B_REG;
                w.src2 = rb;
                w.dest = rb;
                w.reg_write = 1'b1;
            end
            4'd9: begin
                case (ra)
                    2'd0:    w.jmp = JK_JZ;
                    2'd1:    w.jmp = JK_JN;
                    2'd2:    w.jmp = JK_JC;
                    default: w.jmp = JK_JV;
                endcase
                w.alu_src_b = SRC_B_REG;
                w.src2 = rb;
            end
            4'd10: begin   // LOOP
                w.alu_op = OP_DEC_A;
                w.jmp = JK_LOOP;
                w.alu_src_a = SRC_A_REG;
                w.alu_src_b = SRC_B_REG;
                w.src1 = ra;
                w.src2 = rb;
                w.dest = ra;
                w.reg_write = 1'b1;
            end
            4'd11: begin
                if (ra[1]) begin   // RET and RTI
                    w.jmp = JK_RET;
                    w.alu_src_a = SRC_A_REG;
                    w.src1 = 2'd3;
                    w.sp_inc = 1'b1;
                    w.return_flags = (ra == 2'd3);
                end else begin
                    w.jmp = JK_JMP;
                    w.alu_src_b = SRC_B_REG;
                    w.src2 = rb;
                    if (ra == 2'd1) begin   // CALL
                        w.alu_src_a = SRC_A_REG;
                        w.src1 = 2'd3;
                        w.sp_dec = 1'b1;
                        w.mem_write = 1'b1;
                        w.store_pc = 1'b1;
                    end
                end
            end
            4'd12: begin
                if (ra == 2'd0 || ra == 2'd1) begin
                    w.mem_read = (ra == 2'd1);
                    w.dest = rb;
                    w.reg_write = 1'b1;
                end else if (ra == 2'd2) begin
                    w.mem_write = 1'b1;
                    w.src2 = rb;
                end
            end
            4'd13: begin   // LDD
                w.mem_read = 1'b1;
                w.reg_write = 1'b1;
                w.dest = rb;
                w.src1 = ra;
            end
            4'd14: begin   // STD
                w.mem_write = 1'b1;
                w.src1 = ra;
                w.src2 = rb;
            end
            default: ;
        endcase
        return w;
    endfunction

    function automatic ctrl_word_t push_pc_word();
        ctrl_word_t w;
        w = '0;
        w.src1 = 2'd3;
        w.alu_src_a = SRC_A_REG;
        w.alu_src_b = SRC_B_PC;
        w.sp_dec = 1'b1;
        w.mem_write = 1'b1;
        return w;
    endfunction

    function automatic fwd_sel_t forward_source(input logic check, input reg_idx_t r,
                                                output logic load_hit);
        fwd_sel_t sel;
        logic     found;
        sel      = FWD_NONE;
        found    = 1'b0;
        load_hit = 1'b0;
        for (int i = 0; i < 3; i++) begin
            if (check && !found && m_hist[i].writes && m_hist[i].dest == r) begin
                found    = 1'b1;
                sel      = (i == 0) ? FWD_EX : ((i == 1) ? FWD_MEM : FWD_WB);
                load_hit = (i == 0) && m_hist[i].is_load;
            end
        end
        return sel;
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_random(output logic [31:0] r);
        rng_state = xorshift(rng_state);
        r         = rng_state;
    endtask

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Test failed");
            $fatal(1, "output mismatch");
        end
    endtask

    // ------------------------------------------------------------
    // Compare on the falling edge, then step the model
    // ------------------------------------------------------------
    always @(negedge clk) begin
        if (reset) begin
            m_hist[0]  = '0;
            m_hist[1]  = '0;
            m_hist[2]  = '0;
            m_intr_st  = 0;
            m_flush_st = 0;
        end
        e_intr.ack    = (m_intr_st == 1);
        e_intr.active = (m_intr_st == 2);
        e_intr.ret    = (m_intr_st == 3);
        e_ctrl        = e_intr.ack ? push_pc_word() : decode_model(i_instr);
        e_fwd.a       = forward_source(e_ctrl.alu_src_a == SRC_A_REG, e_ctrl.src1, load_a);
        e_fwd.b       = forward_source(e_ctrl.alu_src_b == SRC_B_REG, e_ctrl.src2, load_b);
        e_stall       = load_a | load_b;
        e_flush       = '0;
        if (m_flush_st == 1) begin
            e_flush.f = 1'b1;
            e_flush.d = 1'b1;
        end else if (m_flush_st == 3) begin
            e_flush = '1;
        end else if (m_flush_st == 4) begin
            e_flush.f = i_branch_taken;   // Taken resolved this cycle
            e_flush.d = i_branch_taken;
        end

        compare_value("o_ctrl", 32'(o_ctrl), 32'(e_ctrl));
        compare_value("o_fwd", 32'(o_fwd), 32'(e_fwd));
        compare_value("o_stall", 32'(o_stall), 32'(e_stall));
        compare_value("o_flush", 32'(o_flush), 32'(e_flush));
        compare_value("o_intr", 32'(o_intr), 32'(e_intr));

        exp_stall = e_stall;
        if (!reset) begin
            m_hist[2] = m_hist[1];
            m_hist[1] = m_hist[0];
            m_hist[0] = '0;   // Bubble unless issued
            if (!e_stall) begin
                m_hist[0].is_load = e_ctrl.mem_read;
                m_hist[0].writes  = e_ctrl.reg_write;
                m_hist[0].dest    = e_ctrl.dest;
            end
            case (m_intr_st)
                0:       m_intr_st = i_intr ? 1 : 0;
                1:       m_intr_st = 2;
                2:       m_intr_st = i_intr ? 2 : 3;
                default: m_intr_st = 0;
            endcase
            if (m_flush_st == 0) begin
                if (e_ctrl.jmp == JK_JMP) m_flush_st = 1;
                else if (e_ctrl.jmp == JK_RET) m_flush_st = 2;
                else if (e_ctrl.jmp != JK_NONE) m_flush_st = 4;
            end else if (m_flush_st == 2) begin
                m_flush_st = 3;
            end else begin
                m_flush_st = 0;   // Jumps during a sequence are dropped
            end
        end
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    // Holds the byte over a predicted stall
    task automatic apply_instr(input logic [7:0] b, input logic intr);
        logic [31:0] r;
        logic        done;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            next_random(r);
            i_branch_taken <= r[0];
            i_intr         <= intr;
            if (!exp_stall) begin
                i_instr <= b;
                done = 1'b1;
            end
        end
    endtask

    function automatic logic [7:0] hazard_instr(input logic [31:0] r);
        case (r[2:0])
            3'd0:    return {OPC_ADD, r[11:8]};
            3'd1:    return {OPC_SUB, r[11:8]};
            3'd2:    return {OPC_MOV, r[11:8]};
            3'd3:    return {OPC_LDD, r[11:8]};
            3'd4:    return {OPC_STACK, 2'd1, r[9:8]};   // POP
            3'd5:    return {OPC_LONG, 2'd1, r[9:8]};    // Load from address
            3'd6:    return {OPC_UNARY, r[11:8]};
            default: return {OPC_LOOP, r[11:8]};
        endcase
    endfunction

    function automatic logic [7:0] jump_instr(input logic [31:0] r);
        case (r[9:8])
            2'd0:    return {OPC_JUMP, r[3:0]};
            2'd1:    return {OPC_JCOND, r[3:0]};
            2'd2:    return {OPC_LOOP, r[3:0]};
            default: return r[7:0];
        endcase
    endfunction

    initial begin
        logic [31:0] r;
        int          len;
        clk            = 1'b0;
        reset          = 1'b1;
        i_instr        = 8'h00;
        i_branch_taken = 1'b0;
        i_intr         = 1'b0;
        rng_state      = 32'h38ef_0dcc;
        error_count    = 0;
        exp_stall      = 1'b0;
        m_intr_st      = 0;
        m_flush_st     = 0;

        repeat (16) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < N_RANDOM; i++) begin   // Full decode sweep
            next_random(r);
            apply_instr(r[7:0], 1'b0);
        end
        for (int i = 0; i < N_HAZARD; i++) begin
            next_random(r);
            apply_instr(hazard_instr(r), 1'b0);
        end
        for (int i = 0; i < N_INTR; i++) begin
            next_random(r);
            len = 1 + int'(r[2:0]);
            repeat (len) begin
                next_random(r);
                apply_instr(r[7:0], 1'b1);
            end
            repeat (INTR_GAP) begin
                next_random(r);
                apply_instr(r[7:0], 1'b0);
            end
        end
        for (int i = 0; i < N_JUMP; i++) begin
            next_random(r);
            apply_instr(jump_instr(r), 1'b0);
        end
        repeat (4) apply_instr(8'h00, 1'b0);
        @(posedge clk);   // Last falling edge check is behind us

        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the scenarios did not finish in time");
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== src.f ====
cu_pkg.sv
instr_decoder.sv
intr_sequencer.sv
issue_stage.sv
flush_sequencer.sv
control_unit.sv
tb_control_unit.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_control_unit -f src.f
# Output goes to the console, pass is decided by the last grep
./obj_dir/Vtb_control_unit | tee /dev/stderr | grep -q "Test completed successfully"
echo "Simulation passed"
